// File: Makefile
.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --top-module if_fetch_top \
		source/if_fetch_pkg.sv source/icache_if.sv source/fetch_ctrl.sv \
		source/icache_tags.sv source/icache_data.sv source/axi_read_port.sv \
		source/if_fetch_top.sv

sim:
	verilator --binary --timing --assert -j 0 --top-module tb_if_fetch \
		-f src.f --Mdir obj_dir -o tb_if_fetch
	./obj_dir/tb_if_fetch > sim.log 2>&1; cat sim.log
	@if grep -q "TEST RESULT: FAIL" sim.log; then echo "simulation reported a failure"; exit 1; fi
	@grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// File: source/axi_read_port.sv
`timescale 1ns/1ns
`default_nettype none

module axi_read_port (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [if_fetch_pkg::PC_W-1:0]     pc,
    input  logic                              uncached,
    input  logic                              ar_start,
    input  logic                              rd_start,
    input  logic                              arready,
    output logic                              arvalid,
    output logic [if_fetch_pkg::PC_W-1:0]     araddr,
    output logic [if_fetch_pkg::AXI_ID_W-1:0] arid,
    output logic [7:0]                        arlen,
    output logic [2:0]                        arsize,
    output logic [1:0]                        arburst,
    output logic                              rready,
    input  logic                              rvalid,
    input  logic [1:0]                        rresp,
    input  logic [if_fetch_pkg::LINE_W-1:0]   rdata,
    input  logic                              rlast,
    input  logic [if_fetch_pkg::AXI_ID_W-1:0] rid,
    output logic                              addr_done,
    output logic                              beat_done,
    output logic [if_fetch_pkg::LINE_W-1:0]   line
);
    import if_fetch_pkg::*;

    logic beat_ok;

    // ##################################################
    // AR channel
    // ##################################################
    assign arvalid = ar_start;
    assign arid    = FETCH_ID;
    assign arlen   = 8'd0;
    assign arburst = BURST_FIXED;

    // cached reads fetch the whole aligned line
    assign araddr = uncached ? pc : {pc[PC_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
    assign arsize = uncached ? SIZE_WORD : SIZE_DWORD;

    assign addr_done = arvalid && arready;

    // ##################################################
    // R channel
    // ##################################################
    assign rready = rd_start;

    // stray IDs and error responses are dropped, rready stays up
    assign beat_ok   = rvalid && (rid == FETCH_ID) && rlast && (rresp == RESP_OKAY);
    assign beat_done = rready && beat_ok;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            line <= '0;
        end else if (beat_done) begin
            line <= rdata;
        end
    end

endmodule

`default_nettype wire

// File: source/fetch_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_ctrl #(
    parameter int SETS = if_fetch_pkg::DEF_SETS
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [if_fetch_pkg::PC_W-1:0] pc,
    input  logic                          valid_in,
    input  logic                          fence_i,
    input  logic                          mem_ok,
    input  logic                          addr_done,
    input  logic                          beat_done,
    output logic                          valid_out,
    output logic                          ok,
    output logic                          uncached,
    output logic                          ar_start,
    output logic                          rd_start,
    output logic                          sel_axi,
    icache_if.ctrl                        cache
);
    import if_fetch_pkg::*;

    localparam int INDEX_W = $clog2(SETS);

    fetch_state_t state;
    fetch_state_t state_next;
    logic         accept;

    // ##################################################
    // address split
    // ##################################################
    assign cache.index    = pc[OFFSET_W +: INDEX_W];
    assign cache.tag      = pc[PC_W-1 : OFFSET_W+INDEX_W];
    assign cache.word_sel = pc[OFFSET_W-1];

    // the low half of the address space bypasses the cache
    assign uncached = !pc[PC_W-1];
    assign sel_axi  = uncached;

    // no new fetch starts while the cache is being invalidated
    assign accept = (state == st_idle) && valid_in && !fence_i;

    // ##################################################
    // state machine
    // ##################################################
    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (accept) begin
                    if (!uncached && cache.hit) begin
                        state_next = st_read_cache;
                    end else begin
                        state_next = st_axi_addr;
                    end
                end
            end
            st_read_cache: begin
                state_next = st_finish;
            end
            st_axi_addr: begin
                if (addr_done) begin
                    state_next = st_axi_data;
                end
            end
            st_axi_data: begin
                if (beat_done) begin
                    state_next = uncached ? st_finish : st_write_cache;
                end
            end
            st_write_cache: begin
                // read the freshly written line back through the hit path
                state_next = st_read_cache;
            end
            st_finish: begin
                if (mem_ok) begin
                    state_next = st_idle;
                end
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    // ##################################################
    // outputs
    // ##################################################
    assign cache.fill = (state == st_write_cache);
    assign ar_start   = (state == st_axi_addr);
    assign rd_start   = (state == st_axi_data);

    assign valid_out = valid_in && (state == st_finish);
    assign ok        = !valid_in || (state == st_finish);

endmodule

`default_nettype wire

// File: source/icache_data.sv
`timescale 1ns/1ns
`default_nettype none

module icache_data #(
    parameter int WAYS = if_fetch_pkg::DEF_WAYS,
    parameter int SETS = if_fetch_pkg::DEF_SETS
) (
    input  logic                              clk,
    input  logic [if_fetch_pkg::LINE_W-1:0]   line,
    input  logic                              sel_axi,
    output logic [if_fetch_pkg::INST_W-1:0]   inst,
    icache_if.data                            cache
);
    import if_fetch_pkg::*;

    localparam int INDEX_W = $clog2(SETS);
    localparam int WAY_W   = $clog2(WAYS);

    logic [LINE_W-1:0] line_mem [WAYS][SETS];

    logic [INDEX_W-1:0] rd_index;
    logic [WAY_W-1:0]   rd_way;
    logic [LINE_W-1:0]  stored_line;
    logic [LINE_W-1:0]  src_line;

    // refill goes to the way the tag store picked
    always_ff @(posedge clk) begin
        if (cache.fill) begin
            line_mem[cache.victim_way][cache.index] <= line;
        end
    end

    assign rd_index    = cache.index;
    assign rd_way      = cache.hit_way;
    assign stored_line = line_mem[rd_way][rd_index];

    // uncached fetches and misses take the beat captured from AXI
    assign src_line = (sel_axi || !cache.hit) ? line : stored_line;

    // word_sel picks the upper instruction of the line
    always_comb begin
        if (cache.word_sel) begin
            inst = src_line[INST_W +: INST_W];
        end else begin
            inst = src_line[0 +: INST_W];
        end
    end

endmodule

`default_nettype wire

// File: source/icache_if.sv
`timescale 1ns/1ns
`default_nettype none

interface icache_if #(
    parameter int WAYS = if_fetch_pkg::DEF_WAYS,
    parameter int SETS = if_fetch_pkg::DEF_SETS
);
    import if_fetch_pkg::*;

    localparam int INDEX_W = $clog2(SETS);
    localparam int TAG_W   = PC_W - INDEX_W - OFFSET_W;
    localparam int WAY_W   = $clog2(WAYS);

    logic [INDEX_W-1:0] index;
    logic [TAG_W-1:0]   tag;
    logic               word_sel;
    logic               fill;
    logic               hit;
    logic [WAY_W-1:0]   hit_way;
    logic [WAY_W-1:0]   victim_way;

    modport ctrl (output index, tag, word_sel, fill, input hit);
    modport tags (input index, tag, fill, output hit, hit_way, victim_way);
    modport data (input index, word_sel, fill, hit, hit_way, victim_way);

endinterface

`default_nettype wire

// File: source/icache_tags.sv
`timescale 1ns/1ns
`default_nettype none

module icache_tags #(
    parameter int WAYS = if_fetch_pkg::DEF_WAYS,
    parameter int SETS = if_fetch_pkg::DEF_SETS
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   fence_i,
    icache_if.tags cache
);
    import if_fetch_pkg::*;

    localparam int INDEX_W = $clog2(SETS);
    localparam int TAG_W   = PC_W - INDEX_W - OFFSET_W;
    localparam int WAY_W   = $clog2(WAYS);

    logic [SETS-1:0][WAYS-1:0] valid_bits;
    logic [TAG_W-1:0]          tag_mem [WAYS][SETS];

    logic [WAYS-1:0]  way_hit;
    logic [WAY_W-1:0] hit_way;
    logic [WAY_W-1:0] victim_way;

    // ##################################################
    // lookup
    // ##################################################
    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            way_hit[w] = valid_bits[cache.index][w] &&
                         (tag_mem[w][cache.index] == cache.tag);
        end
    end

    // walking down leaves the lowest matching way in each result
    always_comb begin
        hit_way    = '0;
        victim_way = '0;
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (way_hit[w]) begin
                hit_way = WAY_W'(w);
            end
            if (!valid_bits[cache.index][w]) begin
                victim_way = WAY_W'(w);
            end
        end
    end

    assign cache.hit        = |way_hit;
    assign cache.hit_way    = hit_way;
    assign cache.victim_way = victim_way;

    // ##################################################
    // update
    // ##################################################
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_bits <= '0;
        end else if (fence_i) begin
            valid_bits <= '0;
        end else if (cache.fill) begin
            valid_bits[cache.index][victim_way] <= 1'b1;
        end
    end

    // a tag written during a fence stays behind a cleared valid bit
    always_ff @(posedge clk) begin
        if (cache.fill) begin
            tag_mem[victim_way][cache.index] <= cache.tag;
        end
    end

endmodule

`default_nettype wire

// File: source/if_fetch_pkg.sv
`default_nettype none

package if_fetch_pkg;

    // ##################################################
    // widths
    // ##################################################
    localparam int PC_W     = 32;
    localparam int INST_W   = 32;
    localparam int LINE_W   = 64;
    localparam int OFFSET_W = 3;

    // default cache geometry, the top level passes these down
    localparam int DEF_WAYS = 8;
    localparam int DEF_SETS = 64;

    // ##################################################
    // AXI codes
    // ##################################################
    localparam int AXI_ID_W = 4;

    localparam logic [AXI_ID_W-1:0] FETCH_ID    = '0;
    localparam logic [1:0]          RESP_OKAY   = 2'b00;
    localparam logic [1:0]          BURST_FIXED = 2'b00;
    localparam logic [2:0]          SIZE_WORD   = 3'b010;
    localparam logic [2:0]          SIZE_DWORD  = 3'b011;

    typedef enum logic [2:0] {
        st_idle,
        st_read_cache,
        st_axi_addr,
        st_axi_data,
        st_write_cache,
        st_finish
    } fetch_state_t;

endpackage

`default_nettype wire

// File: source/if_fetch_top.sv
`timescale 1ns/1ns
`default_nettype none

module if_fetch_top #(
    parameter int WAYS = if_fetch_pkg::DEF_WAYS,
    parameter int SETS = if_fetch_pkg::DEF_SETS
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [if_fetch_pkg::PC_W-1:0]     pc,
    input  logic                              valid_in,
    input  logic                              fence_i,
    input  logic                              mem_ok,
    output logic                              valid_out,
    output logic                              ok,
    output logic [if_fetch_pkg::INST_W-1:0]   inst,
    input  logic                              arready,
    output logic                              arvalid,
    output logic [if_fetch_pkg::PC_W-1:0]     araddr,
    output logic [if_fetch_pkg::AXI_ID_W-1:0] arid,
    output logic [7:0]                        arlen,
    output logic [2:0]                        arsize,
    output logic [1:0]                        arburst,
    output logic                              rready,
    input  logic                              rvalid,
    input  logic [1:0]                        rresp,
    input  logic [if_fetch_pkg::LINE_W-1:0]   rdata,
    input  logic                              rlast,
    input  logic [if_fetch_pkg::AXI_ID_W-1:0] rid
);
    import if_fetch_pkg::*;

    logic              uncached;
    logic              ar_start;
    logic              rd_start;
    logic              sel_axi;
    logic              addr_done;
    logic              beat_done;
    logic [LINE_W-1:0] line;

    icache_if #(.WAYS(WAYS), .SETS(SETS)) cache_bus ();

    fetch_ctrl #(.SETS(SETS)) i_ctrl (
        .clk       (clk),
        .rst       (rst),
        .pc        (pc),
        .valid_in  (valid_in),
        .fence_i   (fence_i),
        .mem_ok    (mem_ok),
        .addr_done (addr_done),
        .beat_done (beat_done),
        .valid_out (valid_out),
        .ok        (ok),
        .uncached  (uncached),
        .ar_start  (ar_start),
        .rd_start  (rd_start),
        .sel_axi   (sel_axi),
        .cache     (cache_bus.ctrl)
    );

    icache_tags #(.WAYS(WAYS), .SETS(SETS)) i_tags (
        .clk     (clk),
        .rst     (rst),
        .fence_i (fence_i),
        .cache   (cache_bus.tags)
    );

    icache_data #(.WAYS(WAYS), .SETS(SETS)) i_data (
        .clk     (clk),
        .line    (line),
        .sel_axi (sel_axi),
        .inst    (inst),
        .cache   (cache_bus.data)
    );

    axi_read_port i_axi (
        .clk       (clk),
        .rst       (rst),
        .pc        (pc),
        .uncached  (uncached),
        .ar_start  (ar_start),
        .rd_start  (rd_start),
        .arready   (arready),
        .arvalid   (arvalid),
        .araddr    (araddr),
        .arid      (arid),
        .arlen     (arlen),
        .arsize    (arsize),
        .arburst   (arburst),
        .rready    (rready),
        .rvalid    (rvalid),
        .rresp     (rresp),
        .rdata     (rdata),
        .rlast     (rlast),
        .rid       (rid),
        .addr_done (addr_done),
        .beat_done (beat_done),
        .line      (line)
    );

endmodule

`default_nettype wire

// File: src.f
source/if_fetch_pkg.sv
source/icache_if.sv
source/fetch_ctrl.sv
source/icache_tags.sv
source/icache_data.sv
source/axi_read_port.sv
source/if_fetch_top.sv
test/axi_read_model.sv
test/tb_if_fetch.sv

// File: test/axi_read_model.sv
`timescale 1ns/1ns
`default_nettype none

module axi_read_model #(
    parameter logic [31:0] SEED = 32'h1
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              force_bad,
    output logic [15:0]                       bad_beats,
    output logic                              arready,
    input  logic                              arvalid,
    input  logic [if_fetch_pkg::PC_W-1:0]     araddr,
    output logic                              rvalid,
    output logic [1:0]                        rresp,
    output logic [if_fetch_pkg::LINE_W-1:0]   rdata,
    output logic                              rlast,
    output logic [if_fetch_pkg::AXI_ID_W-1:0] rid,
    input  logic                              rready
);
    import if_fetch_pkg::*;

    typedef enum logic [1:0] {
        m_idle,
        m_delay,
        m_bad,
        m_good
    } model_state_t;

    model_state_t      state;
    logic [31:0]       rnd;
    logic [PC_W-1:0]   addr_q;
    logic [1:0]        delay;
    logic              bad_kind;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // every line is a fixed hash of its aligned address
    function automatic logic [LINE_W-1:0] line_hash(input logic [PC_W-1:0] addr);
        logic [31:0] lo;
        logic [31:0] hi;
        lo = xorshift32(addr ^ 32'h2545_f491);
        hi = xorshift32(lo ^ 32'h9e37_79b9);
        return {hi, lo};
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= m_idle;
            rnd       <= SEED;
            arready   <= 1'b0;
            rvalid    <= 1'b0;
            rresp     <= RESP_OKAY;
            rdata     <= '0;
            rlast     <= 1'b0;
            rid       <= FETCH_ID;
            addr_q    <= '0;
            delay     <= '0;
            bad_kind  <= 1'b0;
            bad_beats <= '0;
        end else begin
            rnd <= xorshift32(rnd);
            case (state)
                m_idle: begin
                    if (arvalid && arready) begin
                        addr_q  <= {araddr[PC_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
                        arready <= 1'b0;
                        delay   <= rnd[1:0];
                        state   <= m_delay;
                    end else begin
                        // arready comes and goes about half the time
                        arready <= rnd[0];
                    end
                end
                m_delay: begin
                    if (delay != 2'd0) begin
                        delay <= delay - 2'd1;
                    end else if (force_bad || rnd[2:0] == 3'd0) begin
                        // a beat the fetch port has to drop, alternating the two kinds
                        rvalid    <= 1'b1;
                        rlast     <= 1'b1;
                        rdata     <= ~line_hash(addr_q);
                        rid       <= bad_kind ? ~FETCH_ID : FETCH_ID;
                        rresp     <= bad_kind ? RESP_OKAY : 2'b10;
                        bad_kind  <= !bad_kind;
                        bad_beats <= bad_beats + 16'd1;
                        state     <= m_bad;
                    end else begin
                        rvalid <= 1'b1;
                        rlast  <= 1'b1;
                        rdata  <= line_hash(addr_q);
                        rid    <= FETCH_ID;
                        rresp  <= RESP_OKAY;
                        state  <= m_good;
                    end
                end
                m_bad: begin
                    rvalid <= 1'b1;
                    rlast  <= 1'b1;
                    rdata  <= line_hash(addr_q);
                    rid    <= FETCH_ID;
                    rresp  <= RESP_OKAY;
                    state  <= m_good;
                end
                m_good: begin
                    if (rvalid && rready) begin
                        rvalid <= 1'b0;
                        rlast  <= 1'b0;
                        state  <= m_idle;
                    end
                end
                default: begin
                    state <= m_idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: test/tb_if_fetch.sv
`timescale 1ns/1ns
`default_nettype none

module tb_if_fetch;
    import if_fetch_pkg::*;

    localparam int WAYS    = DEF_WAYS;
    localparam int SETS    = DEF_SETS;
    localparam int INDEX_W = $clog2(SETS);
    localparam int TAG_W   = PC_W - INDEX_W - OFFSET_W;

    // about 30 fetches of at most 25 cycles each plus reset, with a wide margin
    localparam int MAX_CYCLES = 4000;

    logic                clk;
    logic                rst;
    logic [PC_W-1:0]     pc;
    logic                valid_in;
    logic                fence_i;
    logic                mem_ok;
    logic                valid_out;
    logic                ok;
    logic [INST_W-1:0]   inst;
    logic                arready;
    logic                arvalid;
    logic [PC_W-1:0]     araddr;
    logic [AXI_ID_W-1:0] arid;
    logic [7:0]          arlen;
    logic [2:0]          arsize;
    logic [1:0]          arburst;
    logic                rready;
    logic                rvalid;
    logic [1:0]          rresp;
    logic [LINE_W-1:0]   rdata;
    logic                rlast;
    logic [AXI_ID_W-1:0] rid;
    logic                force_bad;
    logic [15:0]         bad_beats;
    logic [15:0]         bad_before;
    logic [PC_W-1:0]     base;

    int cycles   = 0;
    int errors   = 0;
    int checks   = 0;
    int tests    = 0;
    int ar_count = 0;
    int err_mark = 0;

    bit               ref_valid [SETS][WAYS];
    logic [TAG_W-1:0] ref_tag   [SETS][WAYS];

    logic              ar_pending;
    logic              r_pending;
    logic              out_hold;
    logic [INST_W-1:0] held_inst;

    if_fetch_top #(.WAYS(WAYS), .SETS(SETS)) i_dut (.*);

    axi_read_model #(.SEED(32'h586c_995d)) i_mem (.*);

    always #2 clk = ~clk;

    // ##################################################
    // helpers
    // ##################################################
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [LINE_W-1:0] line_hash(input logic [PC_W-1:0] addr);
        logic [31:0] lo;
        logic [31:0] hi;
        lo = xorshift32(addr ^ 32'h2545_f491);
        hi = xorshift32(lo ^ 32'h9e37_79b9);
        return {hi, lo};
    endfunction

    // bit 2 of the pc picks the upper half of the line
    function automatic logic [INST_W-1:0] inst_of(input logic [PC_W-1:0] addr);
        logic [LINE_W-1:0] l;
        l = line_hash({addr[PC_W-1:OFFSET_W], {OFFSET_W{1'b0}}});
        return addr[2] ? l[63:32] : l[31:0];
    endfunction

    // looks the pc up in the reference tags and fills it on a miss
    function automatic bit ref_access(input logic [PC_W-1:0] addr);
        logic [INDEX_W-1:0] idx;
        logic [TAG_W-1:0]   tg;
        bit                 hit;
        int                 victim;
        idx    = addr[OFFSET_W +: INDEX_W];
        tg     = addr[PC_W-1 -: TAG_W];
        hit    = 1'b0;
        victim = -1;
        for (int w = 0; w < WAYS; w++) begin
            if (ref_valid[idx][w] && ref_tag[idx][w] == tg) begin
                hit = 1'b1;
            end
            if (victim < 0 && !ref_valid[idx][w]) begin
                victim = w;
            end
        end
        // a full set gives up way 0
        if (!hit) begin
            if (victim < 0) begin
                victim = 0;
            end
            ref_valid[idx][victim] = 1'b1;
            ref_tag[idx][victim]   = tg;
        end
        return hit;
    endfunction

    task automatic compare_hex(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("error %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic require(input bit cond, input string what);
        checks++;
        assert (cond) else begin
            $display("%s", what);
            errors++;
        end
    endtask

    // hold > 0 keeps mem_ok low for that many cycles of valid_out
    task automatic run_fetch(input logic [PC_W-1:0] addr, input int hold);
        bit hit;
        bit done;
        int ar_before;
        int k;
        int lat;
        int held;
        hit = 1'b0;
        if (addr[PC_W-1]) begin
            hit = ref_access(addr);
        end
        @(posedge clk);
        ar_before = ar_count;
        pc       <= addr;
        valid_in <= 1'b1;
        mem_ok   <= (hold == 0);
        k    = 0;
        lat  = -1;
        held = 0;
        done = 1'b0;
        while (!done) begin
            @(posedge clk);
            k++;
            if (valid_out) begin
                if (lat < 0) begin
                    lat = k - 1;
                end
                if (mem_ok) begin
                    done = 1'b1;
                end else begin
                    held++;
                    if (held >= hold) begin
                        mem_ok <= 1'b1;
                    end
                end
            end
        end
        compare_hex("inst", 64'(inst), 64'(inst_of(addr)));
        compare_hex("arvalid handshakes", 64'(ar_count - ar_before), hit ? 64'd0 : 64'd1);
        if (hit) begin
            compare_hex("hit latency", 64'(lat), 64'd2);
        end
        valid_in <= 1'b0;
        mem_ok   <= 1'b1;
    endtask

    task automatic pulse_fence();
        @(posedge clk);
        fence_i <= 1'b1;
        @(posedge clk);
        fence_i <= 1'b0;
        for (int s = 0; s < SETS; s++) begin
            for (int w = 0; w < WAYS; w++) begin
                ref_valid[s][w] = 1'b0;
            end
        end
    endtask

    task automatic report_test(input string name);
        tests++;
        $display("test %0d %s: %s", tests, name, (errors == err_mark) ? "ok" : "failed");
        err_mark = errors;
    endtask

    // ##################################################
    // per-cycle protocol checks
    // ##################################################
    always @(posedge clk) begin
        if (rst) begin
            ar_pending = 1'b0;
            r_pending  = 1'b0;
            out_hold   = 1'b0;
        end else begin
            if (ar_pending) begin
                require(arvalid, "arvalid dropped before arready was seen");
            end
            if (r_pending) begin
                require(rready, "rready dropped before a qualifying beat arrived");
            end
            if (out_hold) begin
                require(valid_out, "valid_out dropped while mem_ok was low");
                compare_hex("inst", 64'(inst), 64'(held_inst));
            end
            require(ok == (!valid_in || valid_out), "ok does not follow valid_in and finish");
            if (arvalid && arready) begin
                ar_count++;
                compare_hex("araddr", 64'(araddr),
                            64'(pc[PC_W-1] ? {pc[PC_W-1:OFFSET_W], 3'b000} : pc));
                compare_hex("arsize", 64'(arsize),
                            64'(pc[PC_W-1] ? SIZE_DWORD : SIZE_WORD));
                compare_hex("arid", 64'(arid), 64'(FETCH_ID));
                compare_hex("arlen", 64'(arlen), 64'd0);
                compare_hex("arburst", 64'(arburst), 64'(BURST_FIXED));
            end
            ar_pending = arvalid && !arready;
            r_pending  = rready && !(rvalid && rid == FETCH_ID && rlast && rresp == RESP_OKAY);
            out_hold   = valid_out && !mem_ok;
            held_inst  = inst;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, a fetch never completed", cycles);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // ##################################################
    // tests
    // ##################################################
    initial begin
        clk = 1'b0;
        rst       <= 1'b1;
        pc        <= '0;
        valid_in  <= 1'b0;
        fence_i   <= 1'b0;
        mem_ok    <= 1'b1;
        force_bad <= 1'b0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        require(!valid_out, "valid_out high right after reset");
        require(!arvalid, "arvalid high right after reset");
        require(!rready, "rready high right after reset");
        report_test("reset state");

        run_fetch(32'h8000_1234, 0);
        run_fetch(32'h8000_1234, 0);
        run_fetch(32'h8000_1230, 0);
        report_test("miss then hit");

        run_fetch(32'h0000_4004, 0);
        run_fetch(32'h0000_4008, 0);
        run_fetch(32'h0000_4004, 0);
        run_fetch(32'h7fff_fffc, 0);
        report_test("uncached fetch");

        // nine tags at set 5, the ninth evicts way 0
        for (int t = 1; t <= 9; t++) begin
            base = 32'h8000_0028 + 32'(t << 9);
            run_fetch(base, 0);
        end
        run_fetch(32'h8000_0228, 0);
        run_fetch(32'h8000_0428, 0);
        report_test("replacement");

        run_fetch(32'h8000_1230, 0);
        pulse_fence();
        run_fetch(32'h8000_1230, 0);
        run_fetch(32'h8000_0628, 0);
        report_test("fence_i");

        force_bad <= 1'b1;
        bad_before = bad_beats;
        run_fetch(32'h8000_3000, 0);
        run_fetch(32'h8000_3108, 4);
        run_fetch(32'h0000_2204, 3);
        run_fetch(32'h8000_3004, 2);
        force_bad <= 1'b0;
        compare_hex("bad_beats", 64'(bad_beats - bad_before), 64'd3);
        report_test("response filtering and back-pressure");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
